//--- tb/spmv_testdata.txt
// memory image at @00: four words per line, signed value in 31:16, column in 3:0
// xi vector at @20 (signed 16 bit), jobs at @30: kernel base nnz expected_result
@00
00030000 FFFE0004 000A0F07 0005000D
00010001 00070002 FFFF000A 0002000B
00100006 8000000F 8000000F 8000000F
00040003 00030008 01000009 FFF0000E
0001000D 00060005 00020000 00020001
00020002 00020003 00020004 00020005
00020006 00020007 00030009 FFFD0008
0001000C 0000ABC0 0002000D FFFF000E
@20
0001 0002 0003 FFFF 0005 FFFE 0007 000A
FFFD 0004 0064 FF9C 0002 03E8 FFF9 8000
@30
0 00 4 000013E5
0 04 5 FFFFFF5B
1 09 3 C0000000
2 0C 6 0000083F
3 00 2 FFFFFFF9
2 00 0 00000000
1 12 8 00000032
3 1A 6 000007EE

//--- filelist.f
hdl/spmv_reg_pkg.sv
hdl/spmv_data_pkg.sv
hdl/spmv_system_config.sv
hdl/spmv_calc_kernel.sv
hdl/val_read_arbiter.sv
hdl/xi_vector_buffer.sv
hdl/spmv_calc_top.sv
tb/spmv_calc_props.sv
tb/spmv_calc_tb.sv

//--- tb/spmv_calc_tb.sv
// testbench for the sparse matrix-vector engine
// memory model, register tasks, file driven tests and watchdog
`timescale 1ns/100ps
module spmv_calc_tb;
    import spmv_reg_pkg::*;
    import spmv_data_pkg::*;

    localparam int MEM_WORDS = 32;  // memory image at 0x00
    localparam int XI_OFS    = 'h20;
    localparam int JOB_OFS   = 'h30;
    localparam int NUM_JOBS  = 8;
    localparam int POLL_MAX  = 500;

    logic                  axis_clk;
    logic                  rst_n;
    logic                  reg_wr_en;
    logic                  reg_rd_en;
    logic [REG_ADDR_W-1:0] reg_addr;
    logic [REG_DATA_W-1:0] reg_wdata;
    logic [REG_DATA_W-1:0] reg_rdata;
    logic                  reg_rd_valid;
    logic                  mem_rd_req;
    logic [MEM_ADDR_W-1:0] mem_rd_addr;
    logic                  mem_rd_gnt;
    logic                  mem_rd_valid;
    logic [MEM_DATA_W-1:0] mem_rd_data;

    logic [31:0] td [0:JOB_OFS + 4*NUM_JOBS - 1];
    logic        stall_on;
    int          limit_cycles = 0;

    spmv_calc_top UUT (
        .axis_clk     (axis_clk),
        .rst_n        (rst_n),
        .reg_wr_en    (reg_wr_en),
        .reg_rd_en    (reg_rd_en),
        .reg_addr     (reg_addr),
        .reg_wdata    (reg_wdata),
        .reg_rdata    (reg_rdata),
        .reg_rd_valid (reg_rd_valid),
        .mem_rd_req   (mem_rd_req),
        .mem_rd_addr  (mem_rd_addr),
        .mem_rd_gnt   (mem_rd_gnt),
        .mem_rd_valid (mem_rd_valid),
        .mem_rd_data  (mem_rd_data)
    );

    bind spmv_calc_top spmv_calc_props props (
        .axis_clk     (axis_clk),
        .rst_n        (rst_n),
        .reg_rd_en    (reg_rd_en),
        .reg_rd_valid (reg_rd_valid),
        .mem_rd_req   (mem_rd_req),
        .mem_rd_addr  (mem_rd_addr),
        .mem_rd_gnt   (mem_rd_gnt)
    );

    initial begin
        axis_clk = 1'b0;
        forever #10 axis_clk = ~axis_clk;
    end

    task automatic stop_on_failure();
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic compare_word(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            stop_on_failure();
        end
    endtask

    function automatic int reg_of(input int k, input reg_offset_t ofs);
        return k * KERNEL_STRIDE + int'(ofs);
    endfunction

    function automatic int job_kernel(input int j);
        return int'(td[JOB_OFS + 4*j]);
    endfunction

    function automatic logic [31:0] mem_word(input logic [MEM_ADDR_W-1:0] addr);
        if (addr < MEM_WORDS)
            return td[addr];
        return {addr, ~addr};  // locations outside the image
    endfunction

    task automatic idle(input int n);
        repeat (n) @(negedge axis_clk);
    endtask

    // called on a falling edge and returns on the next one
    task automatic reg_write(input int addr, input logic [31:0] data);
        reg_addr  = REG_ADDR_W'(addr);
        reg_wdata = data;
        reg_wr_en = 1'b1;
        @(negedge axis_clk);
        reg_wr_en = 1'b0;
    endtask

    task automatic reg_read(input int addr, output logic [31:0] data);
        reg_addr  = REG_ADDR_W'(addr);
        reg_rd_en = 1'b1;
        @(negedge axis_clk);
        reg_rd_en = 1'b0;
        if (reg_rd_valid !== 1'b1) begin
            $display("register read at address %0h came back without reg_rd_valid", addr);
            stop_on_failure();
        end
        data = reg_rdata;
    endtask

    task automatic load_job(input int j);
        reg_write(reg_of(job_kernel(j), REG_BASE), td[JOB_OFS + 4*j + 1]);
        reg_write(reg_of(job_kernel(j), REG_NNZ), td[JOB_OFS + 4*j + 2]);
    endtask

    task automatic start_kernel(input int k);
        reg_write(reg_of(k, REG_CTRL), 32'h1);
        idle(1);  // start reaches the kernel
    endtask

    task automatic wait_done(input int k);
        logic [31:0] st;
        int          polls;
        st    = '0;
        polls = 0;
        while (st[STAT_DONE_BIT] !== 1'b1) begin
            if (polls == POLL_MAX) begin
                $display("kernel %0d did not set done within %0d status reads", k, POLL_MAX);
                stop_on_failure();
            end
            reg_read(reg_of(k, REG_STATUS), st);
            polls++;
        end
    endtask

    task automatic check_result(input int j, input string name);
        logic [31:0] rd;
        reg_read(reg_of(job_kernel(j), REG_RESULT), rd);
        compare_word(name, td[JOB_OFS + 4*j + 3], rd);
    endtask

    // memory model with all random draws in this process
    initial begin
        int          cyc;
        int          due;
        int          last_due;
        logic [31:0] rsp_data [$];
        int          rsp_due [$];
        mem_rd_gnt   = 1'b0;
        mem_rd_valid = 1'b0;
        mem_rd_data  = '0;
        cyc          = 0;
        last_due     = 0;
        void'($urandom(32'h386e));
        forever begin
            @(negedge axis_clk);
            cyc++;
            mem_rd_valid = 1'b0;
            if (rsp_due.size() != 0 && rsp_due[0] <= cyc) begin
                mem_rd_valid = 1'b1;
                mem_rd_data  = rsp_data.pop_front();
                void'(rsp_due.pop_front());
            end
            mem_rd_gnt = stall_on ? 1'($urandom % 2) : 1'b1;
            if (rst_n && mem_rd_req && mem_rd_gnt) begin
                due = cyc + 1 + int'($urandom % 4);
                if (due <= last_due)
                    due = last_due + 1;  // keep replies in order
                last_due = due;
                rsp_data.push_back(mem_word(mem_rd_addr));
                rsp_due.push_back(due);
            end
        end
    end

    always @(negedge axis_clk) begin
        if (UUT.props.fail_count != 0) begin
            $display("a bound assertion on the top-level ports failed");
            stop_on_failure();
        end
    end

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge axis_clk);
        $display("watchdog expired after %0d cycles", limit_cycles);
        stop_on_failure();
    end

    initial begin
        logic [31:0] rd;
        int          k;
        rst_n     = 1'b0;
        reg_wr_en = 1'b0;
        reg_rd_en = 1'b0;
        reg_addr  = '0;
        reg_wdata = '0;
        stall_on  = 1'b0;
        $readmemh("tb/spmv_testdata.txt", td);
        if ($isunknown(td[JOB_OFS + 4*NUM_JOBS - 1])) begin
            $display("test data file tb/spmv_testdata.txt could not be read");
            stop_on_failure();
        end
        limit_cycles = 200;  // reset, xi load and register traffic
        for (int j = 0; j < NUM_JOBS; j++)
            limit_cycles = limit_cycles + (int'(td[JOB_OFS + 4*j + 2]) + 20) * 4;
        idle(10);
        rst_n = 1'b1;
        idle(1);

        for (k = 0; k < NUM_KERNEL; k++) begin
            reg_read(reg_of(k, REG_STATUS), rd);
            compare_word($sformatf("reset status k%0d", k), 32'h0, rd);
            reg_read(reg_of(k, REG_RESULT), rd);
            compare_word($sformatf("reset result k%0d", k), 32'h0, rd);
        end

        for (int i = 0; i < XI_DEPTH; i++)
            reg_write(XI_REG_BASE + i, td[XI_OFS + i]);
        reg_read(XI_REG_BASE, rd);
        compare_word("xi range reads zero", 32'h0, rd);
        load_job(0);
        start_kernel(job_kernel(0));
        wait_done(job_kernel(0));
        check_result(0, "single job");

        stall_on = 1'b1;
        for (int j = 1; j <= 4; j++)
            load_job(j);
        for (int j = 1; j <= 4; j++)
            reg_write(reg_of(job_kernel(j), REG_CTRL), 32'h1);  // back to back
        for (int j = 1; j <= 4; j++) begin
            wait_done(job_kernel(j));
            check_result(j, $sformatf("parallel job %0d", j));
        end
        stall_on = 1'b0;

        load_job(5);
        start_kernel(job_kernel(5));
        wait_done(job_kernel(5));
        reg_read(reg_of(job_kernel(5), REG_STATUS), rd);
        compare_word("empty row status", 32'h2, rd);
        check_result(5, "empty row result");

        k = job_kernel(6);
        load_job(6);
        start_kernel(k);
        reg_read(reg_of(k, REG_STATUS), rd);
        compare_word("busy before soft reset", 32'h1, rd);
        reg_write(reg_of(k, REG_CTRL), 32'h80);
        idle(1);
        reg_read(reg_of(k, REG_STATUS), rd);
        compare_word("status in soft reset", 32'h0, rd);
        reg_read(reg_of(k, REG_RESULT), rd);
        compare_word("result in soft reset", 32'h0, rd);
        reg_write(reg_of(k, REG_CTRL), 32'h81);  // start while held in reset
        idle(2);
        reg_read(reg_of(k, REG_STATUS), rd);
        compare_word("start ignored in soft reset", 32'h0, rd);
        reg_write(reg_of(k, REG_CTRL), 32'h0);
        start_kernel(k);
        wait_done(k);
        check_result(6, "restart after soft reset");

        k = job_kernel(7);
        reg_read(reg_of(k, REG_STATUS), rd);
        compare_word("done before restart", 32'h2, rd);
        load_job(7);
        start_kernel(k);
        reg_read(reg_of(k, REG_STATUS), rd);
        compare_word("done cleared by restart", 32'h1, rd);
        wait_done(k);
        check_result(7, "restart with new base");

        if (UUT.props.fail_count == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            $display("a bound assertion failed during the run");
            stop_on_failure();
        end
    end

endmodule

//--- tb/spmv_calc_props.sv
// concurrent checks on the top-level ports of the spmv engine
`timescale 1ns/100ps
module spmv_calc_props (
    input logic                                 axis_clk,
    input logic                                 rst_n,
    input logic                                 reg_rd_en,
    input logic                                 reg_rd_valid,
    input logic                                 mem_rd_req,
    input logic [spmv_data_pkg::MEM_ADDR_W-1:0] mem_rd_addr,
    input logic                                 mem_rd_gnt
);
    int fail_count = 0;  // read by the testbench

    // a waiting request keeps its address until granted
    addr_hold: assert property (@(posedge axis_clk) disable iff (!rst_n)
        mem_rd_req && !mem_rd_gnt |=> mem_rd_req && $stable(mem_rd_addr))
    else begin
        $error("mem_rd_addr changed while the request waited for mem_rd_gnt");
        fail_count++;
    end

    rd_valid_follow: assert property (@(posedge axis_clk) disable iff (!rst_n)
        reg_rd_valid == $past(reg_rd_en))
    else begin
        $error("reg_rd_valid did not follow reg_rd_en by one cycle");
        fail_count++;
    end

    quiet_in_reset: assert property (@(posedge axis_clk) !rst_n |-> !mem_rd_req)
    else begin
        $error("mem_rd_req raised during reset");
        fail_count++;
    end

endmodule

//--- hdl/spmv_calc_top.sv
// top level of the sparse matrix-vector engine
// register block, xi buffer, value read arbiter and the kernels
`timescale 1ns/100ps
module spmv_calc_top (
    input  logic                                  axis_clk,
    input  logic                                  rst_n,
    input  logic                                  reg_wr_en,
    input  logic                                  reg_rd_en,
    input  logic [spmv_reg_pkg::REG_ADDR_W-1:0]   reg_addr,
    input  logic [spmv_reg_pkg::REG_DATA_W-1:0]   reg_wdata,
    output logic [spmv_reg_pkg::REG_DATA_W-1:0]   reg_rdata,
    output logic                                  reg_rd_valid,
    output logic                                  mem_rd_req,
    output logic [spmv_data_pkg::MEM_ADDR_W-1:0]  mem_rd_addr,
    input  logic                                  mem_rd_gnt,
    input  logic                                  mem_rd_valid,
    input  logic [spmv_data_pkg::MEM_DATA_W-1:0]  mem_rd_data
);
    import spmv_reg_pkg::*;
    import spmv_data_pkg::*;

    logic [NUM_KERNEL-1:0] kern_start;
    logic [NUM_KERNEL-1:0] kern_clear;
    logic [NUM_KERNEL-1:0] kern_busy;
    logic [NUM_KERNEL-1:0] kern_done;
    logic [MEM_ADDR_W-1:0] kern_base [NUM_KERNEL];
    logic [NNZ_W-1:0]      kern_nnz [NUM_KERNEL];
    logic [ACC_W-1:0]      kern_result [NUM_KERNEL];

    logic                  xi_wr_en;
    logic [XI_IDX_W-1:0]   xi_wr_idx;
    logic [XI_DATA_W-1:0]  xi_wr_data;
    logic [XI_IDX_W-1:0]   xi_rd_idx [NUM_KERNEL];
    logic [XI_DATA_W-1:0]  xi_rd_data [NUM_KERNEL];

    logic [NUM_KERNEL-1:0] rd_req;
    logic [MEM_ADDR_W-1:0] rd_addr [NUM_KERNEL];
    logic [NUM_KERNEL-1:0] rd_gnt;
    logic [NUM_KERNEL-1:0] rd_rsp_valid;
    logic [MEM_DATA_W-1:0] rd_rsp_data;  // shared by all kernels

    spmv_system_config spmv_system_config (
        .axis_clk     (axis_clk),
        .rst_n        (rst_n),
        .reg_wr_en    (reg_wr_en),
        .reg_rd_en    (reg_rd_en),
        .reg_addr     (reg_addr),
        .reg_wdata    (reg_wdata),
        .reg_rdata    (reg_rdata),
        .reg_rd_valid (reg_rd_valid),
        .kern_start   (kern_start),
        .kern_clear   (kern_clear),
        .kern_base    (kern_base),
        .kern_nnz     (kern_nnz),
        .kern_busy    (kern_busy),
        .kern_done    (kern_done),
        .kern_result  (kern_result),
        .xi_wr_en     (xi_wr_en),
        .xi_wr_idx    (xi_wr_idx),
        .xi_wr_data   (xi_wr_data)
    );

    xi_vector_buffer xi_vector_buffer (
        .axis_clk   (axis_clk),
        .rst_n      (rst_n),
        .xi_wr_en   (xi_wr_en),
        .xi_wr_idx  (xi_wr_idx),
        .xi_wr_data (xi_wr_data),
        .xi_rd_idx  (xi_rd_idx),
        .xi_rd_data (xi_rd_data)
    );

    val_read_arbiter val_read_arbiter (
        .axis_clk     (axis_clk),
        .rst_n        (rst_n),
        .rd_req       (rd_req),
        .rd_addr      (rd_addr),
        .rd_gnt       (rd_gnt),
        .rd_rsp_valid (rd_rsp_valid),
        .rd_rsp_data  (rd_rsp_data),
        .mem_rd_req   (mem_rd_req),
        .mem_rd_addr  (mem_rd_addr),
        .mem_rd_gnt   (mem_rd_gnt),
        .mem_rd_valid (mem_rd_valid),
        .mem_rd_data  (mem_rd_data)
    );

    for (genvar i = 0; i < NUM_KERNEL; i++) begin : g_kernel
        spmv_calc_kernel spmv_calc_kernel (
            .axis_clk     (axis_clk),
            .rst_n        (rst_n),
            .kern_start   (kern_start[i]),
            .kern_clear   (kern_clear[i]),
            .kern_base    (kern_base[i]),
            .kern_nnz     (kern_nnz[i]),
            .kern_busy    (kern_busy[i]),
            .kern_done    (kern_done[i]),
            .kern_result  (kern_result[i]),
            .rd_req       (rd_req[i]),
            .rd_addr      (rd_addr[i]),
            .rd_gnt       (rd_gnt[i]),
            .rd_rsp_valid (rd_rsp_valid[i]),
            .rd_rsp_data  (rd_rsp_data),
            .xi_rd_idx    (xi_rd_idx[i]),
            .xi_rd_data   (xi_rd_data[i])
        );
    end

endmodule

//--- hdl/xi_vector_buffer.sv
// dense xi vector storage
// one write port, one registered read port per kernel
`timescale 1ns/100ps
module xi_vector_buffer (
    input  logic                                  axis_clk,
    input  logic                                  rst_n,
    input  logic                                  xi_wr_en,
    input  logic [spmv_data_pkg::XI_IDX_W-1:0]    xi_wr_idx,
    input  logic [spmv_data_pkg::XI_DATA_W-1:0]   xi_wr_data,
    input  logic [spmv_data_pkg::XI_IDX_W-1:0]    xi_rd_idx [spmv_reg_pkg::NUM_KERNEL],
    output logic [spmv_data_pkg::XI_DATA_W-1:0]   xi_rd_data [spmv_reg_pkg::NUM_KERNEL]
);
    import spmv_reg_pkg::*;
    import spmv_data_pkg::*;

    logic [XI_DATA_W-1:0] xi_mem [XI_DEPTH];

    // entries come up as zero
    always_ff @(posedge axis_clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < XI_DEPTH; i++)
                xi_mem[i] <= '0;
        end else if (xi_wr_en) begin
            xi_mem[xi_wr_idx] <= xi_wr_data;
        end
    end

    always_ff @(posedge axis_clk) begin
        for (int k = 0; k < NUM_KERNEL; k++)
            xi_rd_data[k] <= xi_mem[xi_rd_idx[k]];  // old value on same-cycle write
    end

endmodule

//--- hdl/val_read_arbiter.sv
// round-robin arbiter for the shared value memory read port
// in-order routing FIFO steers replies back to the requesting kernel
`timescale 1ns/100ps
module val_read_arbiter (
    input  logic                                  axis_clk,
    input  logic                                  rst_n,
    input  logic [spmv_reg_pkg::NUM_KERNEL-1:0]   rd_req,
    input  logic [spmv_data_pkg::MEM_ADDR_W-1:0]  rd_addr [spmv_reg_pkg::NUM_KERNEL],
    output logic [spmv_reg_pkg::NUM_KERNEL-1:0]   rd_gnt,
    output logic [spmv_reg_pkg::NUM_KERNEL-1:0]   rd_rsp_valid,
    output logic [spmv_data_pkg::MEM_DATA_W-1:0]  rd_rsp_data,
    output logic                                  mem_rd_req,
    output logic [spmv_data_pkg::MEM_ADDR_W-1:0]  mem_rd_addr,
    input  logic                                  mem_rd_gnt,
    input  logic                                  mem_rd_valid,
    input  logic [spmv_data_pkg::MEM_DATA_W-1:0]  mem_rd_data
);
    import spmv_reg_pkg::*;
    import spmv_data_pkg::*;

    logic [KERNEL_IDX_W-1:0] rr_ptr;
    logic [KERNEL_IDX_W-1:0] pick;
    logic                    pick_ok;
    logic [KERNEL_IDX_W-1:0] sel;
    logic                    accept;
    logic                    hold_q;
    logic [KERNEL_IDX_W-1:0] hold_idx;
    logic [MEM_ADDR_W-1:0]   hold_addr;
    logic [KERNEL_IDX_W-1:0] route_mem [ROUTE_DEPTH];
    logic [ROUTE_PTR_W-1:0]  wr_ptr;
    logic [ROUTE_PTR_W-1:0]  rd_ptr;
    logic [KERNEL_IDX_W-1:0] rsp_kern;

    always_comb begin
        logic [KERNEL_IDX_W-1:0] cand;
        pick    = rr_ptr;
        pick_ok = 1'b0;
        for (int i = 0; i < NUM_KERNEL; i++) begin
            cand = KERNEL_IDX_W'((rr_ptr + i) % NUM_KERNEL);
            if (!pick_ok && rd_req[cand]) begin
                pick    = cand;
                pick_ok = 1'b1;
            end
        end
    end

    // a request waiting for its grant is frozen until accepted
    assign sel         = hold_q ? hold_idx : pick;
    assign mem_rd_req  = hold_q || pick_ok;
    assign mem_rd_addr = hold_q ? hold_addr : rd_addr[pick];
    assign accept      = mem_rd_req && mem_rd_gnt;

    always_comb begin
        for (int k = 0; k < NUM_KERNEL; k++)
            rd_gnt[k] = accept && (sel == k);
    end

    always_ff @(posedge axis_clk) begin
        hold_idx  <= sel;
        hold_addr <= mem_rd_addr;
        if (accept)
            route_mem[wr_ptr] <= sel;
    end

    always_ff @(posedge axis_clk or negedge rst_n) begin
        if (!rst_n) begin
            hold_q <= 1'b0;
            rr_ptr <= '0;
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            hold_q <= mem_rd_req && !mem_rd_gnt;
            if (accept) begin
                rr_ptr <= KERNEL_IDX_W'((sel + 1) % NUM_KERNEL);
                wr_ptr <= wr_ptr + 1'b1;  // depth is a power of two
            end
            if (mem_rd_valid)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    assign rsp_kern    = route_mem[rd_ptr];
    assign rd_rsp_data = mem_rd_data;

    always_comb begin
        for (int k = 0; k < NUM_KERNEL; k++)
            rd_rsp_valid[k] = mem_rd_valid && (rsp_kern == k);
    end

endmodule

//--- hdl/spmv_calc_kernel.sv
// one sparse row times dense vector kernel
// fetch FSM with credit counter, multiply-accumulate
`timescale 1ns/100ps
module spmv_calc_kernel (
    input  logic                                  axis_clk,
    input  logic                                  rst_n,
    input  logic                                  kern_start,
    input  logic                                  kern_clear,
    input  logic [spmv_data_pkg::MEM_ADDR_W-1:0]  kern_base,
    input  logic [spmv_data_pkg::NNZ_W-1:0]       kern_nnz,
    output logic                                  kern_busy,
    output logic                                  kern_done,
    output logic [spmv_data_pkg::ACC_W-1:0]       kern_result,
    output logic                                  rd_req,
    output logic [spmv_data_pkg::MEM_ADDR_W-1:0]  rd_addr,
    input  logic                                  rd_gnt,
    input  logic                                  rd_rsp_valid,
    input  logic [spmv_data_pkg::MEM_DATA_W-1:0]  rd_rsp_data,
    output logic [spmv_data_pkg::XI_IDX_W-1:0]    xi_rd_idx,
    input  logic [spmv_data_pkg::XI_DATA_W-1:0]   xi_rd_data
);
    import spmv_data_pkg::*;

    kernel_state_t            state;
    logic [CREDIT_W-1:0]      credits;
    logic [MEM_ADDR_W-1:0]    addr_q;
    logic [NNZ_W-1:0]         issue_left;
    logic [NNZ_W-1:0]         rsp_left;
    logic                     mac_pend;
    logic signed [VAL_W-1:0]  val_q;
    logic signed [ACC_W-1:0]  acc;
    logic signed [ACC_W-1:0]  product;
    logic                     start_ok;
    logic                     issue;
    logic                     rsp_take;

    assign kern_busy   = (state == K_RUN) || (state == K_DRAIN);
    assign kern_done   = (state == K_DONE);
    assign kern_result = acc;

    assign rd_req   = (state == K_RUN) && (credits != '0);
    assign rd_addr  = addr_q;
    assign issue    = rd_req && rd_gnt;
    assign start_ok = kern_start && !kern_busy;
    assign rsp_take = rd_rsp_valid && kern_busy;  // late replies after a clear are dropped

    // xi lookup in the reply cycle and data back one cycle later
    assign xi_rd_idx = rd_rsp_data[IDX_LSB +: XI_IDX_W];
    assign product   = val_q * $signed(xi_rd_data);

    always_ff @(posedge axis_clk) begin
        if (rsp_take)
            val_q <= rd_rsp_data[VAL_LSB +: VAL_W];
    end

    always_ff @(posedge axis_clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= K_IDLE;
            credits    <= '0;
            addr_q     <= '0;
            issue_left <= '0;
            rsp_left   <= '0;
            mac_pend   <= 1'b0;
            acc        <= '0;
        end else if (kern_clear) begin
            state      <= K_IDLE;
            credits    <= '0;
            addr_q     <= '0;
            issue_left <= '0;
            rsp_left   <= '0;
            mac_pend   <= 1'b0;
            acc        <= '0;
        end else begin
            mac_pend <= rsp_take;
            if (start_ok) begin
                acc        <= '0;
                addr_q     <= kern_base;
                issue_left <= kern_nnz;
                rsp_left   <= kern_nnz;
                credits    <= CREDIT_W'(MAX_CREDITS);
                state      <= (kern_nnz == '0) ? K_DONE : K_RUN;
            end else begin
                credits <= credits - CREDIT_W'(issue) + CREDIT_W'(rsp_take);
                if (issue) begin
                    addr_q     <= addr_q + 1'b1;
                    issue_left <= issue_left - 1'b1;
                    if (issue_left == NNZ_W'(1))
                        state <= K_DRAIN;  // last request out
                end
                if (mac_pend) begin
                    acc      <= acc + product;
                    rsp_left <= rsp_left - 1'b1;
                    if (rsp_left == NNZ_W'(1))
                        state <= K_DONE;
                end
            end
        end
    end

endmodule

//--- hdl/spmv_system_config.sv
// register decode, per-kernel config and status readback
// start and soft reset generation, xi vector writes
`timescale 1ns/100ps
module spmv_system_config (
    input  logic                                  axis_clk,
    input  logic                                  rst_n,
    input  logic                                  reg_wr_en,
    input  logic                                  reg_rd_en,
    input  logic [spmv_reg_pkg::REG_ADDR_W-1:0]   reg_addr,
    input  logic [spmv_reg_pkg::REG_DATA_W-1:0]   reg_wdata,
    output logic [spmv_reg_pkg::REG_DATA_W-1:0]   reg_rdata,
    output logic                                  reg_rd_valid,
    output logic [spmv_reg_pkg::NUM_KERNEL-1:0]   kern_start,
    output logic [spmv_reg_pkg::NUM_KERNEL-1:0]   kern_clear,
    output logic [spmv_data_pkg::MEM_ADDR_W-1:0]  kern_base [spmv_reg_pkg::NUM_KERNEL],
    output logic [spmv_data_pkg::NNZ_W-1:0]       kern_nnz [spmv_reg_pkg::NUM_KERNEL],
    input  logic [spmv_reg_pkg::NUM_KERNEL-1:0]   kern_busy,
    input  logic [spmv_reg_pkg::NUM_KERNEL-1:0]   kern_done,
    input  logic [spmv_data_pkg::ACC_W-1:0]       kern_result [spmv_reg_pkg::NUM_KERNEL],
    output logic                                  xi_wr_en,
    output logic [spmv_data_pkg::XI_IDX_W-1:0]    xi_wr_idx,
    output logic [spmv_data_pkg::XI_DATA_W-1:0]   xi_wr_data
);
    import spmv_reg_pkg::*;
    import spmv_data_pkg::*;

    logic [KERNEL_IDX_W-1:0] sel_kern;
    reg_offset_t             sel_ofs;
    logic                    kern_hit;
    logic                    xi_hit;
    logic                    kern_wr;
    logic                    ctrl_wr;
    logic [REG_DATA_W-1:0]   rd_word;

    assign sel_kern = reg_addr[OFFSET_W +: KERNEL_IDX_W];
    assign sel_ofs  = reg_offset_t'(reg_addr[OFFSET_W-1:0]);
    assign kern_hit = reg_addr < KERNEL_SPAN;
    assign xi_hit   = (reg_addr >= XI_REG_BASE) && (reg_addr < XI_REG_BASE + XI_DEPTH);
    assign kern_wr  = reg_wr_en && kern_hit;
    assign ctrl_wr  = kern_wr && (sel_ofs == REG_CTRL);

    // xi entries go straight to the buffer
    assign xi_wr_en   = reg_wr_en && xi_hit;
    assign xi_wr_idx  = XI_IDX_W'(reg_addr - XI_REG_BASE);
    assign xi_wr_data = reg_wdata[XI_DATA_W-1:0];

    always_ff @(posedge axis_clk or negedge rst_n) begin
        if (!rst_n) begin
            kern_start <= '0;
            kern_clear <= '0;
        end else begin
            for (int k = 0; k < NUM_KERNEL; k++) begin
                kern_start[k] <= ctrl_wr && (sel_kern == k) && reg_wdata[CTRL_START_BIT];
                if (ctrl_wr && (sel_kern == k))
                    kern_clear[k] <= reg_wdata[CTRL_SRST_BIT];
            end
        end
    end

    always_ff @(posedge axis_clk) begin
        for (int k = 0; k < NUM_KERNEL; k++) begin
            if (kern_wr && (sel_kern == k)) begin
                if (sel_ofs == REG_BASE)
                    kern_base[k] <= reg_wdata[MEM_ADDR_W-1:0];
                if (sel_ofs == REG_NNZ)
                    kern_nnz[k] <= reg_wdata[NNZ_W-1:0];
            end
        end
    end

    always_comb begin
        rd_word = '0;  // unmapped and write-only words
        if (kern_hit) begin
            case (sel_ofs)
                REG_STATUS: begin
                    rd_word[STAT_BUSY_BIT] = kern_busy[sel_kern];
                    rd_word[STAT_DONE_BIT] = kern_done[sel_kern];
                end
                REG_RESULT: rd_word = kern_result[sel_kern];
                default:    rd_word = '0;
            endcase
        end
    end

    always_ff @(posedge axis_clk or negedge rst_n) begin
        if (!rst_n) begin
            reg_rd_valid <= 1'b0;
            reg_rdata    <= '0;
        end else begin
            reg_rd_valid <= reg_rd_en;
            if (reg_rd_en)
                reg_rdata <= rd_word;
        end
    end

endmodule

//--- hdl/spmv_data_pkg.sv
// data path widths, memory word layout and credit depth
// kernel FSM states
package spmv_data_pkg;

    localparam int MEM_ADDR_W = 16;
    localparam int MEM_DATA_W = 32;

    // value in 31:16 and column index in 3:0 of a memory word
    localparam int VAL_LSB    = 16;
    localparam int VAL_W      = 16;
    localparam int IDX_LSB    = 0;

    localparam int XI_DEPTH   = 16;
    localparam int XI_IDX_W   = $clog2(XI_DEPTH);
    localparam int XI_DATA_W  = 16;

    localparam int ACC_W      = 32;  // wraps
    localparam int NNZ_W      = 16;

    localparam int MAX_CREDITS = 4;
    localparam int CREDIT_W    = $clog2(MAX_CREDITS + 1);

    // enough routing entries for every read that can be in flight
    localparam int ROUTE_DEPTH = spmv_reg_pkg::NUM_KERNEL * MAX_CREDITS;
    localparam int ROUTE_PTR_W = $clog2(ROUTE_DEPTH);

    typedef enum logic [1:0] {
        K_IDLE,
        K_RUN,
        K_DRAIN,
        K_DONE
    } kernel_state_t;

endpackage

//--- hdl/spmv_reg_pkg.sv
// register map of the configuration port
// per-kernel register offsets, control and status bit positions
package spmv_reg_pkg;

    localparam int NUM_KERNEL    = 4;
    localparam int KERNEL_IDX_W  = $clog2(NUM_KERNEL);

    localparam int REG_ADDR_W    = 8;
    localparam int REG_DATA_W    = 32;

    // each kernel owns an 8-word window starting at k*8
    localparam int KERNEL_STRIDE = 8;
    localparam int OFFSET_W      = $clog2(KERNEL_STRIDE);
    localparam int KERNEL_SPAN   = NUM_KERNEL * KERNEL_STRIDE;

    localparam logic [REG_ADDR_W-1:0] XI_REG_BASE = 'h80;  // 16 xi entries from here

    typedef enum logic [OFFSET_W-1:0] {
        REG_CTRL   = 3'd0,
        REG_BASE   = 3'd1,
        REG_NNZ    = 3'd2,
        REG_STATUS = 3'd3,
        REG_RESULT = 3'd4
    } reg_offset_t;

    localparam int CTRL_START_BIT = 0;  // write 1 to start
    localparam int CTRL_SRST_BIT  = 7;  // held as written

    localparam int STAT_BUSY_BIT  = 0;
    localparam int STAT_DONE_BIT  = 1;

endpackage
